/* hw/huff_consts.svh */
`ifndef HUFF_CONSTS_SVH
`define HUFF_CONSTS_SVH

// tree memory depth, node index is clog2 of this
`define HUFF_NODES 128

// longest code the walker can build
`define HUFF_MAX_DEPTH 16

// entries the consumer can buffer
`define HUFF_CREDITS 4

// child word meaning no element below this node
`define HUFF_EMPTY_CHILD 9'h180

`endif

/* hw/huff_tree_pkg.sv */
`include "huff_consts.svh"

package huff_tree_pkg;

    localparam int NODE_IDX_W = $clog2(`HUFF_NODES); // 7 bits for 128 words

    typedef logic [NODE_IDX_W-1:0] node_idx_t;        // tree memory address

    // bit 8 set: internal node, low 7 bits index
    // bit 8 clear: leaf, low 8 bits character
    typedef logic [8:0] child_t;

    typedef struct packed {
        child_t left;                                 // taken first, code bit 0
        child_t right;                                // code bit 1
    } tree_node_t;

endpackage

/* hw/huff_code_pkg.sv */
`include "huff_consts.svh"

package huff_code_pkg;

    localparam int CODE_LEN_W = $clog2(`HUFF_MAX_DEPTH + 1); // holds 0..16

    typedef enum logic [2:0] {
        INIT,       // set up path and fetch root
        FETCH,      // read one node, wait for rvalid
        LEFT,       // look at left child
        RIGHT,      // look at right child
        EMIT,       // hold entry until a credit is free
        BACKTRACK,  // drop right moves up to last left move
        TRACK,      // replay saved path from root
        DONE        // idle, waits for start
    } walk_state_e;

    typedef struct packed {
        logic [7:0]                chr;  // leaf character
        logic [`HUFF_MAX_DEPTH-1:0] bits; // right aligned, first move on top
        logic [CODE_LEN_W-1:0]     len;  // number of used bits
    } code_entry_t;

endpackage

/* hw/tree_mem_if.sv */
`timescale 1ns/1ps

interface tree_mem_if;
    import huff_tree_pkg::*;

    logic       req;    // held until gnt
    logic       we;     // write when set, read otherwise
    node_idx_t  addr;
    tree_node_t wdata;
    logic       gnt;    // one cycle, request taken
    logic       rvalid; // cycle after a read gnt
    tree_node_t rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

/* hw/tree_ram.sv */
`timescale 1ns/1ps
`include "huff_consts.svh"

module tree_ram (
    input  logic                     clk,
    input  logic                     we,
    input  huff_tree_pkg::node_idx_t addr,
    input  huff_tree_pkg::tree_node_t wdata,
    output huff_tree_pkg::tree_node_t rdata
);
    import huff_tree_pkg::*;

    tree_node_t mem [`HUFF_NODES]; // one word per tree node

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;    // host node write
        end
        rdata <= mem[addr];        // registered read, old data on write
    end

endmodule

/* hw/tree_mem_arbiter.sv */
`timescale 1ns/1ps

module tree_mem_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    tree_mem_if.arbiter               ldr,
    tree_mem_if.arbiter               wlk,
    output logic                      ram_we,
    output huff_tree_pkg::node_idx_t  ram_addr,
    output huff_tree_pkg::tree_node_t ram_wdata,
    input  huff_tree_pkg::tree_node_t ram_rdata
);

    logic wlk_turn; // walker wins a tie when set
    logic pick_wlk; // walker owns the port this cycle
    logic rd_pend;  // read issued last cycle
    logic rd_owner; // 1 when the walker issued it

    assign pick_wlk = wlk.req && (!ldr.req || wlk_turn);

    assign ldr.gnt = ldr.req && !pick_wlk;  // same cycle as req
    assign wlk.gnt = pick_wlk;

    // ram port follows the winner
    assign ram_we    = pick_wlk ? wlk.we : (ldr.req && ldr.we);
    assign ram_addr  = pick_wlk ? wlk.addr : ldr.addr;
    assign ram_wdata = pick_wlk ? wlk.wdata : ldr.wdata;

    // read data goes back to whoever read
    assign ldr.rvalid = rd_pend && !rd_owner;
    assign wlk.rvalid = rd_pend && rd_owner;
    assign ldr.rdata  = rd_owner ? '0 : ram_rdata;
    assign wlk.rdata  = rd_owner ? ram_rdata : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wlk_turn <= 1'b0;                 // loader first after reset
            rd_pend  <= 1'b0;
            rd_owner <= 1'b0;
        end else begin
            if (ldr.gnt || wlk.gnt) begin
                wlk_turn <= ldr.gnt;          // other side next time
                rd_owner <= wlk.gnt;
            end
            rd_pend <= (ldr.gnt && !ldr.we) || (wlk.gnt && !wlk.we);
        end
    end

endmodule

/* hw/tree_loader.sv */
`timescale 1ns/1ps

module tree_loader (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      node_we,
    input  huff_tree_pkg::node_idx_t  node_addr,
    input  huff_tree_pkg::tree_node_t node_data,
    input  huff_tree_pkg::node_idx_t  root_in,
    input  logic                      start,
    tree_mem_if.requester             mem,
    output huff_tree_pkg::node_idx_t  root_idx
);
    import huff_tree_pkg::*;

    logic       pend;      // buffered write waiting for gnt
    node_idx_t  pend_addr;
    tree_node_t pend_data;

    // one-deep write buffer, host spaces its writes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend     <= 1'b0;
            root_idx <= '0;
        end else begin
            if (node_we) begin
                pend <= 1'b1;
            end else if (mem.gnt) begin
                pend <= 1'b0;          // taken by arbiter
            end
            if (start) begin
                root_idx <= root_in;   // stable for the whole walk
            end
        end
    end

    always_ff @(posedge clk) begin
        if (node_we) begin
            pend_addr <= node_addr;
            pend_data <= node_data;
        end
    end

    assign mem.req   = pend;
    assign mem.we    = pend;           // loader only writes
    assign mem.addr  = pend_addr;
    assign mem.wdata = pend_data;

endmodule

/* hw/codebook_walker.sv */
`timescale 1ns/1ps
`include "huff_consts.svh"

module codebook_walker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  huff_tree_pkg::node_idx_t   root_idx,
    tree_mem_if.requester              mem,
    output huff_code_pkg::code_entry_t entry,
    output logic                       code_valid,
    input  logic                       credit_ret,
    output logic                       busy,
    output logic                       done
);
    import huff_tree_pkg::*;
    import huff_code_pkg::*;

    localparam int CRED_W = $clog2(`HUFF_CREDITS + 1);

    walk_state_e                state, state_n;
    logic [`HUFF_MAX_DEPTH:0]   path, path_n;     // newest move at bit 0, guard one above
    logic [CODE_LEN_W-1:0]      depth, depth_n;   // moves in path
    logic [CODE_LEN_W-1:0]      pos, pos_n;       // moves replayed so far
    logic                       go_right, go_right_n; // set by backtrack, right after replay
    logic                       rd_req, rd_req_n;
    logic [CRED_W-1:0]          credits;
    node_idx_t                  fetch_addr, addr_n;
    tree_node_t                 cur_node, node_n;
    logic [7:0]                 leaf_char, char_n;
    child_t                     step_child;       // child looked at in LEFT/RIGHT
    child_t                     trk_child;        // child picked by saved path
    logic [`HUFF_MAX_DEPTH-1:0] len_mask;

    assign step_child = (state == RIGHT) ? cur_node.right : cur_node.left;
    assign trk_child  = path[depth - pos - 1'b1] ? cur_node.right : cur_node.left;

    always_comb begin
        state_n    = state;
        path_n     = path;
        depth_n    = depth;
        pos_n      = pos;
        go_right_n = go_right;
        rd_req_n   = rd_req;
        addr_n     = fetch_addr;
        node_n     = cur_node;
        char_n     = leaf_char;
        case (state)
            DONE: begin
                if (start) state_n = INIT;
            end
            INIT: begin                        // root is latched by now
                path_n     = {{`HUFF_MAX_DEPTH{1'b0}}, 1'b1};
                depth_n    = '0;
                pos_n      = '0;
                go_right_n = 1'b0;
                addr_n     = root_idx;
                rd_req_n   = 1'b1;
                state_n    = FETCH;
            end
            FETCH: begin
                if (mem.gnt) rd_req_n = 1'b0;
                if (mem.rvalid) begin
                    node_n = mem.rdata;
                    if (pos < depth) begin
                        state_n = TRACK;        // still replaying
                    end else if (go_right) begin
                        state_n    = RIGHT;
                        go_right_n = 1'b0;
                    end else begin
                        state_n = LEFT;
                    end
                end
            end
            TRACK: begin                       // one step down the saved path
                addr_n   = trk_child[NODE_IDX_W-1:0];
                pos_n    = pos + 1'b1;
                rd_req_n = 1'b1;
                state_n  = FETCH;
            end
            LEFT, RIGHT: begin
                if (step_child == `HUFF_EMPTY_CHILD) begin
                    state_n = DONE;            // nothing below, walk ends
                end else begin
                    path_n  = {path[`HUFF_MAX_DEPTH-1:0], state == RIGHT};
                    depth_n = depth + 1'b1;
                    pos_n   = depth + 1'b1;    // no replay pending
                    if (step_child[8]) begin
                        addr_n   = step_child[NODE_IDX_W-1:0];
                        rd_req_n = 1'b1;
                        state_n  = FETCH;
                    end else begin
                        char_n  = step_child[7:0];
                        state_n = EMIT;
                    end
                end
            end
            EMIT: begin
                if (credits != '0) state_n = BACKTRACK; // entry goes out now
            end
            BACKTRACK: begin
                if (depth == '0) begin
                    state_n = DONE;            // all right moves at root done
                end else begin
                    path_n  = {1'b0, path[`HUFF_MAX_DEPTH:1]};
                    depth_n = depth - 1'b1;
                    if (!path[0]) begin
                        // last left move dropped, replay to its parent
                        go_right_n = 1'b1;
                        pos_n      = '0;
                        addr_n     = root_idx;
                        rd_req_n   = 1'b1;
                        state_n    = FETCH;
                    end
                end
            end
            default: state_n = DONE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= DONE;
            path     <= {{`HUFF_MAX_DEPTH{1'b0}}, 1'b1};
            depth    <= '0;
            pos      <= '0;
            go_right <= 1'b0;
            rd_req   <= 1'b0;
            credits  <= CRED_W'(`HUFF_CREDITS);
            done     <= 1'b0;
        end else begin
            state    <= state_n;
            path     <= path_n;
            depth    <= depth_n;
            pos      <= pos_n;
            go_right <= go_right_n;
            rd_req   <= rd_req_n;
            if (state == INIT) begin
                credits <= CRED_W'(`HUFF_CREDITS); // full credit per walk
            end else begin
                credits <= credits + CRED_W'(credit_ret) - CRED_W'(code_valid);
            end
            done <= (state != DONE) && (state_n == DONE); // one pulse at walk end
        end
    end

    always_ff @(posedge clk) begin
        fetch_addr <= addr_n;
        cur_node   <= node_n;
        leaf_char  <= char_n;
    end

    // strip the guard one from the code bits
    assign len_mask = ~({`HUFF_MAX_DEPTH{1'b1}} << depth);

    assign entry.chr  = leaf_char;
    assign entry.bits = path[`HUFF_MAX_DEPTH-1:0] & len_mask;
    assign entry.len  = depth;

    assign code_valid = (state == EMIT) && (credits != '0);
    assign busy       = (state != DONE);

    assign mem.req   = rd_req;
    assign mem.we    = 1'b0;                   // walker only reads
    assign mem.addr  = fetch_addr;
    assign mem.wdata = '0;

endmodule

/* hw/huffman_codebook_top.sv */
`timescale 1ns/1ps
`include "huff_consts.svh"

module huffman_codebook_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                node_we,
    input  huff_tree_pkg::node_idx_t            node_addr,
    input  huff_tree_pkg::tree_node_t           node_data,
    input  huff_tree_pkg::node_idx_t            root_idx,
    input  logic                                start,
    output logic                                code_valid,
    output logic [7:0]                          code_char,
    output logic [`HUFF_MAX_DEPTH-1:0]          code_bits,
    output logic [huff_code_pkg::CODE_LEN_W-1:0] code_len,
    input  logic                                credit_ret,
    output logic                                busy,
    output logic                                done
);
    import huff_tree_pkg::*;
    import huff_code_pkg::*;

    tree_mem_if ldr_if ();   // loader to arbiter
    tree_mem_if wlk_if ();   // walker to arbiter

    logic        ram_we;
    node_idx_t   ram_addr;
    tree_node_t  ram_wdata;
    tree_node_t  ram_rdata;
    node_idx_t   root_lat;   // root held for the walk
    code_entry_t entry;

    tree_loader u_loader (
        .clk       (clk),
        .rst       (rst),
        .node_we   (node_we),
        .node_addr (node_addr),
        .node_data (node_data),
        .root_in   (root_idx),
        .start     (start),
        .mem       (ldr_if.requester),
        .root_idx  (root_lat)
    );

    codebook_walker u_walker (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .root_idx   (root_lat),
        .mem        (wlk_if.requester),
        .entry      (entry),
        .code_valid (code_valid),
        .credit_ret (credit_ret),
        .busy       (busy),
        .done       (done)
    );

    tree_mem_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .ldr       (ldr_if.arbiter),
        .wlk       (wlk_if.arbiter),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    tree_ram u_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    assign code_char = entry.chr;
    assign code_bits = entry.bits;
    assign code_len  = entry.len;

endmodule

/* sim/tb_huffman_codebook.sv */
`timescale 1ns/1ps
`include "huff_consts.svh"

module tb_huffman_codebook;
    import huff_tree_pkg::*;
    import huff_code_pkg::*;

    localparam int FILE_WORDS   = 256;
    localparam int WALK_TIMEOUT = 3000;                   // cycles including credit drain
    localparam int ENTRY_W      = 8 + `HUFF_MAX_DEPTH + CODE_LEN_W;

    typedef logic [ENTRY_W-1:0] entry_t;                  // {char, bits, len}

    logic                       clk;
    logic                       rst;
    logic                       node_we;
    node_idx_t                  node_addr;
    tree_node_t                 node_data;
    node_idx_t                  root_idx;
    logic                       start;
    logic                       code_valid;
    logic [7:0]                 code_char;
    logic [`HUFF_MAX_DEPTH-1:0] code_bits;
    logic [CODE_LEN_W-1:0]      code_len;
    logic                       credit_ret;
    logic                       busy;
    logic                       done;

    logic [63:0] tests [FILE_WORDS];   // flat word stream of all records
    int          rp;                   // next word to read
    logic [63:0] tname;                // 8 ascii chars
    logic [63:0] delay_mode;           // bit 8 selects random delay up to low byte
    node_idx_t   test_root;
    tree_node_t  model [`HUFF_NODES];  // tb copy of tree memory
    entry_t      file_q [$];           // entries listed in the file
    entry_t      ref_q [$];            // entries from the tb's own walk
    node_idx_t   extra_addr [$];       // writes issued during the walk
    tree_node_t  extra_data [$];
    logic [31:0] lcg_state;
    int          err_value;
    int          err_other;
    int          sent;                 // code_valid pulses this walk
    int          returned;             // credits the DUT has taken this walk
    int          done_cnt;

    huffman_codebook_top uut (
        .clk        (clk),
        .rst        (rst),
        .node_we    (node_we),
        .node_addr  (node_addr),
        .node_data  (node_data),
        .root_idx   (root_idx),
        .start      (start),
        .code_valid (code_valid),
        .code_char  (code_char),
        .code_bits  (code_bits),
        .code_len   (code_len),
        .credit_ret (credit_ret),
        .busy       (busy),
        .done       (done)
    );

    always #50 clk = ~clk;             // 100 ns period

    function automatic logic [63:0] next_word();
        logic [63:0] w;
        w  = (rp < FILE_WORDS) ? tests[rp] : '0; // past the end reads as end marker
        rp = rp + 1;
        return w;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // consumer latency for one credit
    function automatic int credit_delay();
        if (delay_mode[8]) begin
            lcg_state = lcg_next(lcg_state);
            return 1 + int'(lcg_state[23:8] % delay_mode[7:0]);
        end
        return int'(delay_mode[7:0]);
    endfunction

    task automatic check_value(input string what, input int unsigned expv,
                               input int unsigned actv);
        assert (expv == actv) else begin
            err_value++;
            $display("** Error %s %s: expected %0h actual %0h", tname, what, expv, actv);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            err_other++;
            $display("%s: %s", tname, msg);
        end
    endtask

    task automatic host_write(input node_idx_t a, input tree_node_t d);
        @(posedge clk);
        node_we   <= 1'b1;
        node_addr <= a;
        node_data <= d;
        @(posedge clk);
        node_we <= 1'b0;
        repeat (2) @(posedge clk);     // loader buffers one write only
        model[a] = d;
    endtask

    task automatic load_record(output logic more);
        int         n;
        int         i;
        node_idx_t  a;
        tree_node_t d;
        tname = next_word();
        more  = (tname != '0);
        if (more) begin
            test_root  = node_idx_t'(next_word());
            delay_mode = next_word();
            n = int'(next_word());
            for (i = 0; i < n; i++) begin
                a = node_idx_t'(next_word());
                d = tree_node_t'(next_word());
                host_write(a, d);      // tree goes in before start
            end
            extra_addr.delete();
            extra_data.delete();
            n = int'(next_word());
            for (i = 0; i < n; i++) begin
                extra_addr.push_back(node_idx_t'(next_word()));
                extra_data.push_back(tree_node_t'(next_word()));
            end
            file_q.delete();
            n = int'(next_word());
            for (i = 0; i < n; i++) begin
                file_q.push_back({8'(next_word()), 16'(next_word()), CODE_LEN_W'(next_word())});
            end
        end
    endtask

    // left-first dfs on the model that stops at an empty child
    task automatic build_reference(input node_idx_t root);
        child_t                     stk_c [$];
        logic [`HUFF_MAX_DEPTH-1:0] stk_b [$];
        int                         stk_l [$];
        child_t                     c;
        logic [`HUFF_MAX_DEPTH-1:0] b;
        int                         l;
        int                         guard;
        logic                       stop;
        tree_node_t                 nd;
        ref_q.delete();
        stk_c.push_back({2'b10, root}); // root as an internal child
        stk_b.push_back('0);
        stk_l.push_back(0);
        stop  = 1'b0;
        guard = 0;
        while (!stop && stk_c.size() > 0 && guard < 4 * `HUFF_NODES) begin
            c = stk_c.pop_back();
            b = stk_b.pop_back();
            l = stk_l.pop_back();
            guard++;
            if (c == `HUFF_EMPTY_CHILD) begin
                stop = 1'b1;
            end else if (!c[8]) begin
                ref_q.push_back({c[7:0], b, CODE_LEN_W'(l)});
            end else begin
                nd = model[c[NODE_IDX_W-1:0]];
                stk_c.push_back(nd.right); // right popped after left subtree
                stk_b.push_back({b[`HUFF_MAX_DEPTH-2:0], 1'b1});
                stk_l.push_back(l + 1);
                stk_c.push_back(nd.left);
                stk_b.push_back({b[`HUFF_MAX_DEPTH-2:0], 1'b0});
                stk_l.push_back(l + 1);
            end
        end
    endtask

    task automatic cross_check();
        int i;
        check_value("reference entry count", file_q.size(), ref_q.size());
        for (i = 0; i < file_q.size() && i < ref_q.size(); i++) begin
            check_value($sformatf("reference entry %0d", i), file_q[i], ref_q[i]);
        end
    endtask

    // checks entries and busy and returns credits until done and drain
    task automatic watch_walk();
        int     k;
        int     waited;
        int     due [$];               // cycle each credit goes back
        logic   got_done;
        entry_t e;
        k        = 0;
        waited   = 0;
        got_done = 1'b0;
        sent     = 0;
        returned = 0;
        done_cnt = 0;
        while (!(got_done && due.size() == 0) && waited < WALK_TIMEOUT) begin
            @(posedge clk);
            waited++;
            if (code_valid) begin
                check_true(!got_done, "code_valid seen after done");
                check_true(sent - returned < `HUFF_CREDITS, "code_valid with no credit left");
                if (k < file_q.size()) begin
                    e = file_q[k];
                    check_value($sformatf("entry %0d char", k), e[ENTRY_W-1 -: 8], code_char);
                    check_value($sformatf("entry %0d bits", k),
                                e[CODE_LEN_W +: `HUFF_MAX_DEPTH], code_bits);
                    check_value($sformatf("entry %0d len", k), e[CODE_LEN_W-1:0], code_len);
                end else begin
                    check_true(1'b0, "more entries than expected");
                end
                k++;
                sent++;
                due.push_back(waited + credit_delay());
            end
            if (done) begin
                done_cnt++;
                check_true(!busy, "busy still high at done");
                got_done = 1'b1;
            end else begin
                check_true(busy == !got_done, "busy wrong around the walk");
            end
            if (credit_ret) begin
                returned++;            // taken by the DUT at this edge
            end
            if (due.size() > 0 && due[0] <= waited) begin
                credit_ret <= 1'b1;    // one credit per cycle at most
                void'(due.pop_front());
            end else begin
                credit_ret <= 1'b0;
            end
        end
        @(posedge clk);
        credit_ret <= 1'b0;
        check_true(got_done, "timeout waiting for done");
        check_true(due.size() == 0, "timeout returning credits");
        check_value("entry count", file_q.size(), k);
        repeat (4) begin
            @(posedge clk);
            if (done) done_cnt++;      // a late second pulse
        end
        check_value("done pulses", 1, done_cnt);
    endtask

    task automatic issue_extras();
        int i;
        for (i = 0; i < extra_addr.size(); i++) begin
            host_write(extra_addr[i], extra_data[i]);
        end
    endtask

    initial begin
        logic more;
        int   ntests;
        clk        = 1'b0;
        rst        = 1'b1;
        node_we    = 1'b0;
        node_addr  = '0;
        node_data  = '0;
        root_idx   = '0;
        start      = 1'b0;
        credit_ret = 1'b0;
        rp         = 0;
        err_value  = 0;
        err_other  = 0;
        ntests     = 0;
        tname      = "reset   ";
        lcg_state  = 32'hffdd_0794;
        $readmemh("sim/huffman_tests.txt", tests);
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_true(!code_valid && !busy && !done, "outputs not low after reset");
        load_record(more);
        while (more) begin
            build_reference(test_root);
            cross_check();
            @(posedge clk);
            root_idx <= test_root;
            start    <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            fork
                watch_walk();
                issue_extras();    // host traffic while the walker reads
            join
            ntests++;
            load_record(more);
        end
        $display("tests run: %0d, value errors: %0d, other errors: %0d",
                 ntests, err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+hw
hw/huff_tree_pkg.sv
hw/huff_code_pkg.sv
hw/tree_mem_if.sv
hw/tree_ram.sv
hw/tree_mem_arbiter.sv
hw/tree_loader.sv
hw/codebook_walker.sv
hw/huffman_codebook_top.sv
sim/tb_huffman_codebook.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_huffman_codebook -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_huffman_codebook)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx 'All tests passed!'; then
    exit 0
fi
exit 1

/* sim/huffman_tests.txt */
// record: name (8 ascii chars), root, credit mode (bit 8 random, low byte delay or max)
// then: write count + (addr data), extra count + (addr data), entry count + (char bits len)
// one_leaf: leaf A left of the root, nothing on the right
6f6e655f6c656166 00 002
1 00 08380
0
1 41 0 1
// balanced: four leaves at depth two
62616c616e636564 00 001
3 00 20302 01 08242 02 08644
0
4 41 0 2 42 1 2 43 2 2 44 3 2
// skewed_8: one leaf per level down to depth eight
736b657765645f38 00 003
8 00 08301 01 08502 02 08703 03 08904 04 08b05 05 08d06 06 08f07 07 09049
0
9 41 0 1 42 2 2 43 6 3 44 e 4 45 1e 5 46 3e 6 47 7e 7 48 fe 8 49 ff 8
// throttle: five leaves, slow random credit returns
7468726f74746c65 00 13c
4 00 20302 01 20645 02 08644 03 08242
0
5 41 0 3 42 1 3 45 1 2 43 2 2 44 3 2
// busy_mem: root at 0a, host writes to 60..63 while the walk runs
627573795f6d656d 0a 004
2 0a 2165a 0b 0b059
4 60 3ffff 61 00000 62 12345 63 2aaaa
3 58 0 2 59 1 2 5a 1 1
// reloaded: new tree at 30 over the old memory
72656c6f61646564 30 110
4 30 26332 31 0c262 32 0c733 33 0c865
0
5 61 0 2 62 1 2 63 2 2 64 6 3 65 7 3
// end of records
0
